/* common/objPkg.sv */
/*
 * Shared sizes, hit rule and sprite entry layout for the sprite generator.
 * Every RTL block of the generator pulls these in by a wildcard import.
 */
package objPkg;

	// ------------------------------------------------------------------------
	// Sprite list and line geometry
	// ------------------------------------------------------------------------
	localparam int numSprites = 128;
	// 512 bytes, four per entry
	localparam int attrAddrW  = 9;
	localparam int lineLen    = 256;
	// Sprites are square
	localparam int sprSize    = 16;

	// ------------------------------------------------------------------------
	// Pixel and ROM widths
	// ------------------------------------------------------------------------
	localparam int pixPerWord = 4;
	localparam int colorW     = 4;
	localparam int palW       = 3;
	// Palette bank sits above the colour
	localparam int objW       = palW + colorW;
	localparam int romAddrW   = 17;
	localparam int romDataW   = 16;

	// Sprite covers the line when (line + yPos) mod 256 lands in the top 16 rows
	localparam logic [7:0] hitBase = 8'd240;

	// Drawer FSM states
	localparam logic [1:0] drIdle  = 2'd0;
	localparam logic [1:0] drWait  = 2'd1;
	localparam logic [1:0] drWrite = 2'd2;
	// Aborted with a ROM answer still on its way
	localparam logic [1:0] drDrain = 2'd3;

	// One sprite entry, seen as RAM bytes or as decoded fields
	typedef union packed {
		// Indexed by RAM byte offset within the entry
		logic [3:0][7:0] bytes;
		struct packed {
			logic [7:0]      xPos;
			logic [7:0]      tileLo;
			// Double height on the board, unused here
			logic            rsvd;
			logic            flipX;
			logic [palW-1:0] palette;
			logic [2:0]      tileHi;
			logic [7:0]      yPos;
		} f;
	} objEntryU;

endpackage

/* rtl/objAttrRam.sv */
/*
 * Sprite attribute RAM, 128 entries of four bytes.
 * CPU reads and writes on one port, the line scanner reads on the other.
 * Both read ports have one cycle of latency.
 */
`timescale 1ns/1ps

module objAttrRam import objPkg::*; (
	input  logic                 clk,
	input  logic                 rstN,
	// CPU side
	input  logic                 cpuSel,
	input  logic                 cpuWr,
	input  logic [attrAddrW-1:0] cpuAddr,
	input  logic [7:0]           cpuDin,
	output logic [7:0]           cpuDout,
	// Scanner side
	input  logic [attrAddrW-1:0] attrRdAddr,
	output logic [7:0]           attrRdData
);

	logic [7:0] mem [1 << attrAddrW];

	// ------------------------------------------------------------------------
	// CPU port
	// ------------------------------------------------------------------------

	// Byte write when selected
	always_ff @(posedge clk) begin
		if (cpuSel && cpuWr) begin
			mem[cpuAddr] <= cpuDin;
		end
	end

	// Registered readback
	// Bus floats high whenever the CPU is not reading us
	always_ff @(posedge clk) begin
		if (!rstN) begin
			cpuDout <= 8'hFF;
		end else if (cpuSel && !cpuWr) begin
			cpuDout <= mem[cpuAddr];
		end else begin
			cpuDout <= 8'hFF;
		end
	end

	// ------------------------------------------------------------------------
	// Scanner port
	// ------------------------------------------------------------------------

	// Read only, free running
	always_ff @(posedge clk) begin
		attrRdData <= mem[attrRdAddr];
	end

	// Write strobe only means something inside a selected cycle
	assert property (@(posedge clk) disable iff (!rstN) cpuWr |-> cpuSel)
		else $error("cpuWr high without cpuSel");

endmodule

/* objScan/objLineScanner.sv */
/*
 * Line scanner. On each lineStart walks all sprite entries, four RAM reads
 * per entry, and tests them against the next line. Hits are handed to the
 * sprite drawer one at a time, stalling the walk while a hit waits.
 */
`timescale 1ns/1ps

module objLineScanner import objPkg::*; (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 lineStart,
	input  logic [7:0]           vpos,
	output logic [attrAddrW-1:0] attrRdAddr,
	input  logic [7:0]           attrRdData,
	input  logic                 drawBusy,
	output logic                 hitStb,
	output objEntryU             hitEntry,
	output logic [3:0]           hitLine
);

	// Walk position
	logic       scanning;
	logic [6:0] entIdx;
	logic [1:0] byteIdx;
	// Read pipeline, one cycle behind the address
	logic       rdValid;
	logic [1:0] rdByte;
	// Line being prepared
	logic [7:0] target;
	objEntryU   asmEntry;
	// Hit held until the drawer is free
	logic       pendHit;
	logic       issue;
	logic       lastByte;
	logic       isHit;
	logic [7:0] row;

	// Hold the walk while a hit is parked
	assign issue      = scanning && !pendHit;
	assign attrRdAddr = {entIdx, byteIdx};
	// Byte 3 on the data bus completes the entry
	assign lastByte   = rdValid && (rdByte == 2'd3);
	// yPos came in with byte 0, three reads earlier
	assign row        = target + asmEntry.f.yPos;
	assign isHit      = lastByte && (row >= hitBase);

	// ------------------------------------------------------------------------
	// Walk and hit handoff
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rstN) begin
			scanning <= 1'b0;
			entIdx   <= '0;
			byteIdx  <= '0;
			rdValid  <= 1'b0;
			pendHit  <= 1'b0;
			hitStb   <= 1'b0;
		end else if (lineStart) begin
			// Restart, dropping any read or hit of the old line
			scanning <= 1'b1;
			entIdx   <= '0;
			byteIdx  <= '0;
			rdValid  <= 1'b0;
			pendHit  <= 1'b0;
			hitStb   <= 1'b0;
		end else begin
			rdValid <= issue;
			hitStb  <= 1'b0;
			if (issue) begin
				byteIdx <= byteIdx + 2'd1;
				if (byteIdx == 2'd3) begin
					entIdx <= entIdx + 7'd1;
					// Last entry read out, idle until next line
					if (entIdx == 7'(numSprites - 1)) begin
						scanning <= 1'b0;
					end
				end
			end
			// Park a new hit, or release the parked one
			if (isHit) begin
				pendHit <= 1'b1;
			end else if (pendHit && !drawBusy) begin
				pendHit <= 1'b0;
				hitStb  <= 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Entry assembly
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		rdByte <= byteIdx;
		if (rdValid) begin
			asmEntry.bytes[rdByte] <= attrRdData;
		end
		// Copy out so the next entry can assemble behind it
		if (isHit) begin
			hitEntry.bytes[2:0] <= asmEntry.bytes[2:0];
			hitEntry.bytes[3]   <= attrRdData;
			hitLine             <= 4'(row - hitBase);
		end
		// Prepare the line after the one starting
		if (lineStart) begin
			target <= vpos + 8'd1;
		end
	end

	// Drawer must be idle whenever it is handed a sprite
	assert property (@(posedge clk) disable iff (!rstN) hitStb |-> !drawBusy)
		else $error("hitStb while drawer busy");

endmodule

/* objScan/objSpriteDrawer.sv */
/*
 * Sprite drawer. Takes one hit sprite, fetches its four ROM words for the
 * hit line and writes the opaque pixels into the back line buffer.
 * lineStart aborts the sprite; a ROM answer still due is waited out.
 */
`timescale 1ns/1ps

module objSpriteDrawer import objPkg::*; (
	input  logic                clk,
	input  logic                rstN,
	input  logic                lineStart,
	input  logic                hitStb,
	input  objEntryU            hitEntry,
	input  logic [3:0]          hitLine,
	output logic                drawBusy,
	output logic                romReq,
	output logic [romAddrW-1:0] romAddr,
	input  logic                romRdy,
	input  logic [romDataW-1:0] romData,
	output logic                wrStb,
	output logic [7:0]          wrX,
	output logic [objW-1:0]     wrPix
);

	logic [1:0]          state;
	objEntryU            ent;
	logic [3:0]          sprLine;
	// Word within the sprite line, then nibble within the word
	logic [1:0]          quarter;
	logic [1:0]          pixCnt;
	logic [romDataW-1:0] word;
	logic [colorW-1:0]   curNib;
	logic [3:0]          pixK;
	logic [3:0]          xOff;
	logic                lastPix;
	logic                reqOpen;

	assign drawBusy = (state != drIdle);
	// Leftmost pixel in the top nibble
	assign curNib   = word[romDataW-1 -: colorW];
	assign pixK     = {quarter, pixCnt};
	// Mirror within the 16 pixels
	assign xOff     = ent.f.flipX ? 4'(sprSize - 1) - pixK : pixK;
	assign lastPix  = (pixCnt == 2'(pixPerWord - 1));
	// Colour 0 is see-through; nothing lands across a buffer swap
	assign wrStb    = (state == drWrite) && (curNib != '0) && !lineStart;
	assign wrX      = ent.f.xPos + {4'd0, xOff};
	assign wrPix    = {ent.f.palette, curNib};

	// ------------------------------------------------------------------------
	// FSM
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rstN) begin
			state  <= drIdle;
			romReq <= 1'b0;
		end else begin
			romReq <= 1'b0;
			case (state)
				drIdle: begin
					if (hitStb && !lineStart) begin
						state  <= drWait;
						romReq <= 1'b1;
					end
				end
				drWait: begin
					if (romRdy) begin
						state <= lineStart ? drIdle : drWrite;
					end else if (lineStart) begin
						state <= drDrain;
					end
				end
				drWrite: begin
					if (lineStart) begin
						state <= drIdle;
					end else if (lastPix) begin
						// Four words per sprite line
						if (quarter == 2'd3) begin
							state <= drIdle;
						end else begin
							state  <= drWait;
							romReq <= 1'b1;
						end
					end
				end
				default: begin
					// Late answer is thrown away
					if (romRdy) begin
						state <= drIdle;
					end
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Sprite, address and pixel shift registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (state == drIdle && hitStb) begin
			ent     <= hitEntry;
			sprLine <= hitLine;
			quarter <= 2'd0;
			romAddr <= {hitEntry.f.tileHi, hitEntry.f.tileLo, hitLine, 2'd0};
		end
		if (state == drWait && romRdy) begin
			word   <= romData;
			pixCnt <= 2'd0;
		end
		if (state == drWrite) begin
			word   <= {word[romDataW-colorW-1:0], {colorW{1'b0}}};
			pixCnt <= pixCnt + 2'd1;
			if (lastPix) begin
				quarter <= quarter + 2'd1;
				romAddr <= {ent.f.tileHi, ent.f.tileLo, sprLine, quarter + 2'd1};
			end
		end
	end

	// ROM side view of the request, kept apart from the FSM
	always_ff @(posedge clk) begin
		if (!rstN) begin
			reqOpen <= 1'b0;
		end else if (romRdy) begin
			reqOpen <= 1'b0;
		end else if (romReq) begin
			reqOpen <= 1'b1;
		end
	end

	// At most one ROM request in flight
	assert property (@(posedge clk) disable iff (!rstN) romReq |-> !reqOpen)
		else $error("romReq with a request outstanding");

endmodule

/* objLineBuf/objLineBuffer.sv */
/*
 * Ping-pong sprite line buffers. The drawer fills the back buffer while the
 * front one is shifted out one pixel per pixStb and cleared behind the read.
 * lineStart swaps the two. After reset both are swept to zero.
 */
`timescale 1ns/1ps

module objLineBuffer import objPkg::*; (
	input  logic            clk,
	input  logic            rstN,
	input  logic            lineStart,
	input  logic            pixStb,
	input  logic            wrStb,
	input  logic [7:0]      wrX,
	input  logic [objW-1:0] wrPix,
	output logic [objW-1:0] obj
);

	// Bank being displayed
	logic                 frontSel;
	logic [7:0]           pixCnt;
	// Reset sweep
	logic                 clrBusy;
	logic [7:0]           clrCnt;
	logic [1:0][objW-1:0] rdData;

	// ------------------------------------------------------------------------
	// Display side and swap
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rstN) begin
			frontSel <= 1'b0;
			pixCnt   <= '0;
			clrBusy  <= 1'b1;
			clrCnt   <= '0;
			obj      <= '0;
		end else begin
			if (clrBusy) begin
				clrCnt <= clrCnt + 8'd1;
				if (clrCnt == 8'(lineLen - 1)) begin
					clrBusy <= 1'b0;
				end
			end
			if (lineStart) begin
				frontSel <= ~frontSel;
				pixCnt   <= '0;
			end else if (pixStb) begin
				obj    <= rdData[frontSel];
				pixCnt <= pixCnt + 8'd1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Banks
	// ------------------------------------------------------------------------
	for (genvar b = 0; b < 2; b++) begin : gBank
		logic [objW-1:0] mem [lineLen];
		logic            bankWe;
		logic [7:0]      bankAddr;
		logic [objW-1:0] bankData;

		// One write port, owner depends on the bank's role
		always_comb begin
			if (clrBusy) begin
				bankWe   = 1'b1;
				bankAddr = clrCnt;
				bankData = '0;
			end else if (frontSel == 1'(b)) begin
				// Clear behind the display read
				bankWe   = pixStb;
				bankAddr = pixCnt;
				bankData = '0;
			end else begin
				bankWe   = wrStb;
				bankAddr = wrX;
				bankData = wrPix;
			end
		end

		always_ff @(posedge clk) begin
			if (bankWe) begin
				mem[bankAddr] <= bankData;
			end
		end

		assign rdData[b] = mem[pixCnt];
	end

	// Swap and pixel readout never share a cycle
	assert property (@(posedge clk) disable iff (!rstN) !(pixStb && lineStart))
		else $error("pixStb in lineStart cycle");

endmodule

/* rtl/objTop.sv */
/*
 * Sprite generator top level. Joins attribute RAM, line scanner,
 * sprite drawer and line buffers; lineStart fans out to all three stages.
 */
`timescale 1ns/1ps

module objTop import objPkg::*; (
	input  logic                 clk,
	input  logic                 rstN,
	// CPU
	input  logic                 cpuSel,
	input  logic                 cpuWr,
	input  logic [attrAddrW-1:0] cpuAddr,
	input  logic [7:0]           cpuDin,
	output logic [7:0]           cpuDout,
	// Video timing
	input  logic                 lineStart,
	input  logic                 pixStb,
	input  logic [7:0]           vpos,
	// Graphics ROM
	output logic                 romReq,
	output logic [romAddrW-1:0]  romAddr,
	input  logic                 romRdy,
	input  logic [romDataW-1:0]  romData,
	// Palette and colour, 0 when no sprite
	output logic [objW-1:0]      obj
);

	logic [attrAddrW-1:0] attrRdAddr;
	logic [7:0]           attrRdData;
	// Scanner to drawer
	logic                 hitStb;
	objEntryU             hitEntry;
	logic [3:0]           hitLine;
	logic                 drawBusy;
	// Drawer to line buffer
	logic                 wrStb;
	logic [7:0]           wrX;
	logic [objW-1:0]      wrPix;

	objAttrRam attrRam0 (
		.clk(clk), .rstN(rstN),
		.cpuSel(cpuSel), .cpuWr(cpuWr), .cpuAddr(cpuAddr), .cpuDin(cpuDin), .cpuDout(cpuDout),
		.attrRdAddr(attrRdAddr), .attrRdData(attrRdData)
	);

	objLineScanner scan0 (
		.clk(clk), .rstN(rstN), .lineStart(lineStart), .vpos(vpos),
		.attrRdAddr(attrRdAddr), .attrRdData(attrRdData), .drawBusy(drawBusy),
		.hitStb(hitStb), .hitEntry(hitEntry), .hitLine(hitLine)
	);

	objSpriteDrawer draw0 (
		.clk(clk), .rstN(rstN), .lineStart(lineStart),
		.hitStb(hitStb), .hitEntry(hitEntry), .hitLine(hitLine), .drawBusy(drawBusy),
		.romReq(romReq), .romAddr(romAddr), .romRdy(romRdy), .romData(romData),
		.wrStb(wrStb), .wrX(wrX), .wrPix(wrPix)
	);

	objLineBuffer lineBuf0 (
		.clk(clk), .rstN(rstN), .lineStart(lineStart), .pixStb(pixStb),
		.wrStb(wrStb), .wrX(wrX), .wrPix(wrPix), .obj(obj)
	);

endmodule

/* sim/objTb.sv */
/*
 * Testbench for the sprite generator. Models the CPU, the graphics ROM and
 * the video timing, keeps a shadow of the sprite list and checks every
 * displayed pixel and every ROM request against a model line.
 */
`timescale 1ns/1ps

module objTb import objPkg::*; ();

	localparam int lineCycles = 2048;
	// Six lines per test, six tests, plus reset, RAM setup and the first line
	localparam int cycLimit   = 6 * lineCycles * 6 + 8 * lineCycles;
	// Entries parked here never reach the short range of lines used
	localparam logic [7:0] parkY = 8'd100;

	logic                 clk;
	logic                 rstN;
	logic                 cpuSel;
	logic                 cpuWr;
	logic [attrAddrW-1:0] cpuAddr;
	logic [7:0]           cpuDin;
	logic [7:0]           cpuDout;
	logic                 lineStart;
	logic                 pixStb;
	logic [7:0]           vpos;
	logic                 romReq;
	logic [romAddrW-1:0]  romAddr;
	logic                 romRdy;
	logic [romDataW-1:0]  romData;
	logic [objW-1:0]      obj;

	// Sprite list as the CPU wrote it
	logic [7:0]           shadow [1 << attrAddrW];
	// Line on display, and line being drawn
	logic [objW-1:0]      dispExp [lineLen];
	logic [objW-1:0]      nextExp [lineLen];
	logic [7:0]           tgtLine;
	logic                 videoOn;
	int                   lineCyc;
	int                   lineNo;
	logic [7:0]           pixIdx;
	logic                 chkPend;
	logic [7:0]           chkX;
	// ROM model state
	int                   romCnt;
	logic [romAddrW-1:0]  romAddrQ;
	logic [romAddrW-1:0]  prevRomAddr;
	int                   seed = 32'h9f6be3d6;
	// Counters
	int                   cycCnt;
	int                   errCnt;
	int                   pixChk;
	int                   litChk;
	int                   romChk;
	int                   errAt;
	int                   pixAt;
	int                   litAt;
	int                   romAt;
	int                   passTests;
	int                   failTests;
	event                 lineEv;

	objTop dut0 (
		.clk(clk), .rstN(rstN),
		.cpuSel(cpuSel), .cpuWr(cpuWr), .cpuAddr(cpuAddr), .cpuDin(cpuDin), .cpuDout(cpuDout),
		.lineStart(lineStart), .pixStb(pixStb), .vpos(vpos),
		.romReq(romReq), .romAddr(romAddr), .romRdy(romRdy), .romData(romData),
		.obj(obj)
	);

	always #10 clk = ~clk;

	// ------------------------------------------------------------------------
	// Reference rules
	// ------------------------------------------------------------------------

	// Nibble n of a ROM word, n = 0 on top
	function automatic logic [3:0] romNibble(logic [romAddrW-1:0] a, int n);
		return 4'(a[3:0] + n);
	endfunction

	function automatic logic [romDataW-1:0] romWord(logic [romAddrW-1:0] a);
		return {romNibble(a, 0), romNibble(a, 1), romNibble(a, 2), romNibble(a, 3)};
	endfunction

	// Line within sprite i for line ln, or -1 when not hit
	function automatic int hitRow(int i, logic [7:0] ln);
		logic [7:0] row;
		row = ln + shadow[4 * i];
		if (row >= hitBase) begin
			return int'(row - hitBase);
		end
		return -1;
	endfunction

	function automatic logic [10:0] tileOf(int i);
		return {shadow[4 * i + 1][2:0], shadow[4 * i + 2]};
	endfunction

	// Model of the line buffer contents for line ln
	task automatic buildLine(input logic [7:0] ln);
		int r;
		logic [romAddrW-1:0] a;
		logic [3:0] nib;
		logic [7:0] x;
		logic [7:0] attr;
		for (int j = 0; j < lineLen; j++) begin
			nextExp[j] = '0;
		end
		// Ascending order so the higher entry overwrites
		for (int i = 0; i < numSprites; i++) begin
			r = hitRow(i, ln);
			attr = shadow[4 * i + 1];
			if (r >= 0) begin
				for (int k = 0; k < sprSize; k++) begin
					a = {tileOf(i), 4'(r), 2'(k / pixPerWord)};
					nib = romNibble(a, k % pixPerWord);
					x = shadow[4 * i + 3] + 8'(attr[6] ? sprSize - 1 - k : k);
					if (nib != 4'd0) begin
						nextExp[x] = {attr[5:3], nib};
					end
				end
			end
		end
	endtask

	// Request must belong to a sprite hit on the line being drawn
	task automatic checkRomReq();
		logic found;
		found = 1'b0;
		romChk++;
		assert (romCnt == 0) else begin
			$display("[ERROR] %0t: romReq while a request is outstanding", $time);
			errCnt++;
		end
		if (romAddr[1:0] != 2'd0) begin
			assert (romAddr[16:2] == prevRomAddr[16:2] &&
				romAddr[1:0] == prevRomAddr[1:0] + 2'd1)
			else begin
				$display("[ERROR] %0t: ROM quarter out of order at %h", $time, romAddr);
				errCnt++;
			end
		end
		for (int i = 0; i < numSprites; i++) begin
			if (hitRow(i, tgtLine) == int'(romAddr[5:2]) && tileOf(i) == romAddr[16:6]) begin
				found = 1'b1;
			end
		end
		assert (found) else begin
			$display("[ERROR] %0t: ROM address %h matches no hit sprite", $time, romAddr);
			errCnt++;
		end
		prevRomAddr = romAddr;
		romAddrQ = romAddr;
		romCnt = 1 + ($unsigned($random(seed)) % 6);
	endtask

	// ------------------------------------------------------------------------
	// ROM model and video timing
	// ------------------------------------------------------------------------
	always @(posedge clk) begin
		#2;
		lineStart = 1'b0;
		pixStb = 1'b0;
		romRdy = 1'b0;
		if (romCnt > 0) begin
			romCnt--;
			if (romCnt == 0) begin
				romRdy = 1'b1;
				romData = romWord(romAddrQ);
			end
		end
		// Checked before the target moves on
		if (romReq) begin
			checkRomReq();
		end
		if (videoOn) begin
			if (lineCyc == 0) begin
				lineStart = 1'b1;
				vpos = 8'(lineNo);
				lineNo++;
				dispExp = nextExp;
				tgtLine = vpos + 8'd1;
				buildLine(tgtLine);
				->lineEv;
			end else if (lineCyc % 4 == 0 && lineCyc <= 4 * lineLen) begin
				pixStb = 1'b1;
				pixIdx = 8'(lineCyc / 4 - 1);
			end
			lineCyc = (lineCyc == lineCycles - 1) ? 0 : lineCyc + 1;
		end
	end

	// obj follows a pixel strobe by one cycle
	always @(posedge clk) begin
		chkPend <= pixStb;
		chkX <= pixIdx;
	end

	always @(negedge clk) begin
		if (chkPend) begin
			pixChk++;
			if (dispExp[chkX] != '0) begin
				litChk++;
			end
			assert (obj == dispExp[chkX]) else begin
				$display("[ERROR] %0t: pixel %0d of line %0d is %h, expected %h",
					$time, chkX, vpos, obj, dispExp[chkX]);
				errCnt++;
			end
		end
	end

	always @(posedge clk) begin
		cycCnt++;
		if (cycCnt >= cycLimit) begin
			$display("Timeout after %0d cycles, the tests did not finish", cycCnt);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// CPU and test helpers
	// ------------------------------------------------------------------------
	task automatic cpuWrite(input logic [attrAddrW-1:0] a, input logic [7:0] d);
		@(posedge clk);
		#2;
		cpuSel = 1'b1;
		cpuWr = 1'b1;
		cpuAddr = a;
		cpuDin = d;
		shadow[a] = d;
		@(posedge clk);
		#2;
		cpuSel = 1'b0;
		cpuWr = 1'b0;
	endtask

	// With sel low the bus reads FF
	task automatic cpuRead(input logic sel, input logic [attrAddrW-1:0] a);
		logic [7:0] exp;
		exp = sel ? shadow[a] : 8'hFF;
		@(posedge clk);
		#2;
		cpuSel = sel;
		cpuWr = 1'b0;
		cpuAddr = a;
		@(posedge clk);
		#2;
		cpuSel = 1'b0;
		assert (cpuDout == exp) else begin
			$display("[ERROR] %0t: CPU read %h sel %b gave %h, expected %h",
				$time, a, sel, cpuDout, exp);
			errCnt++;
		end
	endtask

	task automatic setSprite(input int idx, input logic [7:0] y, input logic flip,
		input logic [2:0] pal, input logic [10:0] tile, input logic [7:0] x);
		cpuWrite(9'(4 * idx), y);
		cpuWrite(9'(4 * idx + 1), {1'b0, flip, pal, tile[10:8]});
		cpuWrite(9'(4 * idx + 2), tile[7:0]);
		cpuWrite(9'(4 * idx + 3), x);
	endtask

	// Past the display and drawing part of the n-th next line
	task automatic toWindow(input int n);
		repeat (n) @(lineEv);
		repeat (1200) @(posedge clk);
	endtask

	task automatic markTest();
		errAt = errCnt;
		pixAt = pixChk;
		litAt = litChk;
		romAt = romChk;
	endtask

	task automatic endTest(input string name, input int minPix, input int minLit, input int minRom);
		int errs;
		if (pixChk - pixAt < minPix) begin
			$display("Test %s: too few displayed pixels were checked", name);
			errCnt++;
		end
		if (litChk - litAt < minLit) begin
			$display("Test %s: no sprite pixels reached the display", name);
			errCnt++;
		end
		if (romChk - romAt < minRom) begin
			$display("Test %s: too few ROM requests were seen", name);
			errCnt++;
		end
		errs = errCnt - errAt;
		if (errs == 0) begin
			passTests++;
			$display("Test %s: ok", name);
		end else begin
			failTests++;
			$display("Test %s: FAILED with %0d errors", name, errs);
		end
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------
	initial begin
		logic [attrAddrW-1:0] a;
		logic [7:0] d;
		logic [7:0] base;
		clk = 1'b0;
		rstN = 1'b0;
		cpuSel = 1'b0;
		cpuWr = 1'b0;
		cpuAddr = '0;
		cpuDin = '0;
		lineStart = 1'b0;
		pixStb = 1'b0;
		vpos = '0;
		romRdy = 1'b0;
		romData = '0;
		videoOn = 1'b0;
		for (int j = 0; j < lineLen; j++) begin
			dispExp[j] = '0;
			nextExp[j] = '0;
		end
		repeat (8) @(posedge clk);
		#2;
		rstN = 1'b1;

		markTest();
		for (int n = 0; n < 16; n++) begin
			a = attrAddrW'($random(seed));
			d = 8'($random(seed));
			cpuWrite(a, d);
			cpuRead(1'b1, a);
			cpuRead(1'b0, a);
		end
		// Whole list parked, also covers the buffer clear sweep
		for (int i = 0; i < numSprites; i++) begin
			setSprite(i, parkY, 1'b0, 3'd0, 11'd0, 8'd0);
		end
		endTest("cpu access", 0, 0, 0);

		@(negedge clk);
		videoOn = 1'b1;
		toWindow(1);

		// First covered line is three lines on
		markTest();
		base = vpos;
		setSprite(5, hitBase - (base + 8'd3), 1'b0, 3'd3, 11'h123, 8'd40);
		toWindow(6);
		endTest("single sprite", 1000, 1, 0);

		// Same graphics mirrored, window ending mid test
		markTest();
		base = vpos;
		setSprite(5, parkY, 1'b0, 3'd0, 11'd0, 8'd0);
		setSprite(7, hitBase - (base - 8'd12), 1'b1, 3'd3, 11'h123, 8'd40);
		toWindow(6);
		endTest("flip x", 1000, 1, 0);

		markTest();
		base = vpos;
		setSprite(7, parkY, 1'b0, 3'd0, 11'd0, 8'd0);
		setSprite(10, hitBase - (base + 8'd1), 1'b0, 3'd1, 11'h050, 8'd100);
		setSprite(20, hitBase - (base + 8'd1), 1'b0, 3'd6, 11'h2a1, 8'd106);
		toWindow(6);
		endTest("overlap", 1000, 1, 0);

		// Top tile bits, wrap at the right edge, one mirrored
		markTest();
		base = vpos;
		setSprite(10, parkY, 1'b0, 3'd0, 11'd0, 8'd0);
		setSprite(20, parkY, 1'b0, 3'd0, 11'd0, 8'd0);
		setSprite(30, hitBase - (base + 8'd2), 1'b0, 3'd2, 11'h7ff, 8'd248);
		setSprite(31, hitBase - (base + 8'd2), 1'b1, 3'd4, 11'h400, 8'd8);
		setSprite(90, hitBase - (base + 8'd2), 1'b0, 3'd7, 11'h013, 8'd180);
		toWindow(6);
		endTest("rom addresses", 1000, 1, 12);

		markTest();
		setSprite(30, parkY, 1'b0, 3'd0, 11'd0, 8'd0);
		setSprite(31, parkY, 1'b0, 3'd0, 11'd0, 8'd0);
		setSprite(90, parkY, 1'b0, 3'd0, 11'd0, 8'd0);
		toWindow(6);
		endTest("clearing", 1000, 0, 0);

		$display("Summary: %0d tests passed, %0d tests failed, %0d pixels, %0d ROM requests",
			passTests, failTests, pixChk, romChk);
		if (failTests == 0 && errCnt == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

/* files.f */
common/objPkg.sv
rtl/objAttrRam.sv
objScan/objLineScanner.sv
objScan/objSpriteDrawer.sv
objLineBuf/objLineBuffer.sv
rtl/objTop.sv
sim/objTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the sprite generator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f files.f \
	--top-module objTb \
	-o objSim

out=$(./obj_dir/objSim)
echo "$out"

if grep -q "STATUS: PASS" <<< "$out"; then
	exit 0
else
	exit 1
fi
